// ==== flist.f ====
+incdir+sim
logic/mips_pkg.sv
logic/op_if.sv
logic/divider.sv
logic/instr_decode.sv
logic/op_queue.sv
logic/execute_unit.sv
logic/mips_exec_top.sv
sim/tb_mips_exec.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f flist.f --top-module tb_mips_exec -o tb_mips_exec

./obj_dir/tb_mips_exec | tee sim.log

if grep -q "Simulation passed" sim.log; then
  exit 0
else
  exit 1
fi

// ==== sim/tb_tasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic lfsr_bit();
  logic fb;
  fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
  lfsr_state = {lfsr_state[30:0], fb};
  return fb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_bit()};
  end
  return v;
endfunction

task automatic test_reg_alu();
  func_t funcs[12];
  funcs = '{FUNC_SLL, FUNC_SRL, FUNC_SRA, FUNC_SLLV, FUNC_SRLV, FUNC_SRAV,
            FUNC_ADDU, FUNC_SUBU, FUNC_AND, FUNC_OR, FUNC_XOR, FUNC_NOR};
  for (int r = 0; r < 2; r++) begin
    foreach (funcs[i]) begin
      issue_r(funcs[i], rand_bits(32), rand_bits(32), 5'(rand_bits(5)));
    end
  end
endtask

task automatic test_imm_ops();
  opcode_t ops[9];
  ops = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW, OP_SW};
  foreach (ops[i]) begin
    issue_i(ops[i], rand_bits(32), 16'(rand_bits(16)));
    // Negative immediate shows the extension
    issue_i(ops[i], rand_bits(32), 16'h8000 | 16'(rand_bits(15)));
  end
  issue_i(OP_SLTIU, 32'h0000_0005, 16'hffff);
  issue_i(OP_SLTI, 32'h0000_0005, 16'hffff);
endtask

task automatic test_overflow();
  issue_r(FUNC_ADD, 32'h7fff_ffff, 32'h0000_0001, 5'd0);
  issue_r(FUNC_ADD, 32'h0000_0001, 32'h0000_0002, 5'd0);
  issue_r(FUNC_ADD, 32'h8000_0000, 32'hffff_ffff, 5'd0);
  issue_r(FUNC_SUB, 32'h8000_0000, 32'h0000_0001, 5'd0);
  issue_r(FUNC_SUB, 32'h0000_0005, 32'h0000_0003, 5'd0);
  issue_r(FUNC_SUB, 32'h7fff_ffff, 32'hffff_ffff, 5'd0);
  issue_i(OP_ADDI, 32'h7fff_ffff, 16'h0001);
  issue_i(OP_ADDI, 32'hffff_ffff, 16'hffff);
  issue_r(FUNC_ADDU, 32'h7fff_ffff, 32'h0000_0001, 5'd0);
  issue_r(FUNC_SUBU, 32'h8000_0000, 32'h0000_0001, 5'd0);
endtask

task automatic test_mult();
  issue_r(FUNC_MULT, rand_bits(32), rand_bits(32), 5'd0);
  issue_r(FUNC_MULTU, rand_bits(32), rand_bits(32), 5'd0);
  issue_r(FUNC_MULT, 32'hffff_fff9, 32'h0000_1234, 5'd0);
  issue_r(FUNC_MULT, 32'h8000_0000, 32'h8000_0000, 5'd0);
  issue_r(FUNC_MULTU, 32'hffff_ffff, 32'hffff_ffff, 5'd0);
  issue_r(FUNC_MULT, 32'hffff_ffff, 32'hffff_ffff, 5'd0);
endtask

task automatic test_div();
  issue_r(FUNC_DIV, rand_bits(32), rand_bits(16), 5'd0);
  issue_r(FUNC_DIVU, rand_bits(32), rand_bits(20), 5'd0);
  issue_r(FUNC_DIV, 32'hffff_ff9c, 32'h0000_0007, 5'd0);
  issue_r(FUNC_DIV, 32'h0000_0064, 32'hffff_fff9, 5'd0);
  issue_r(FUNC_DIV, 32'hffff_ff9c, 32'hffff_fff9, 5'd0);
  issue_r(FUNC_DIVU, 32'hffff_ff9c, 32'h0000_0007, 5'd0);
  issue_r(FUNC_DIVU, 32'h1234_5678, 32'h0000_0000, 5'd0);
  issue_r(FUNC_DIV, 32'h1234_5678, 32'h0000_0000, 5'd0);
  issue_r(FUNC_DIV, 32'hedcb_a988, 32'h0000_0000, 5'd0);
endtask

task automatic test_backpressure();
  // Start from an empty queue so that only this division can fill it
  while (exp_q.size() != 0) @(negedge clk);
  full_seen = 1'b0;
  issue_r(FUNC_DIV, rand_bits(32), rand_bits(12), 5'd0);
  issue_r(FUNC_ADDU, rand_bits(32), rand_bits(32), 5'd0);
  issue_i(OP_ORI, rand_bits(32), 16'(rand_bits(16)));
  // Opcode 02 is a jump, which the decoder drops
  strobe({6'h02, 26'h0}, rand_bits(32), rand_bits(32));
  issue_r(FUNC_XOR, rand_bits(32), rand_bits(32), 5'd0);
  issue_r(FUNC_MULTU, rand_bits(32), rand_bits(32), 5'd0);
  issue_i(OP_LW, rand_bits(32), 16'(rand_bits(16)));
  issue_r(FUNC_SRA, rand_bits(32), 32'h8000_0f00, 5'd4);
  if (!full_seen) begin
    $display("full_o never rose while operations waited behind a division");
    errors++;
  end
endtask

`endif

// ==== sim/tb_mips_exec.sv ====
`timescale 1ns/10ps

module tb_mips_exec
  import mips_pkg::*;
();

  // Upper bound on strobes over all tests, each allowed a full division
  localparam int MAX_INSTR      = 96;
  localparam int TIMEOUT_CYCLES = MAX_INSTR * (DIV_STEPS + 8) + 200;

  typedef struct {
    logic [XLEN-1:0] res;
    res_kind_t       kind;
    logic            ovf;
    logic [XLEN-1:0] hi;
    logic [XLEN-1:0] lo;
  } expect_t;

  logic            clk;
  logic            arst_n_i;
  logic            instr_valid_i;
  logic [XLEN-1:0] instr_i;
  logic [XLEN-1:0] rs_i;
  logic [XLEN-1:0] rt_i;
  logic            full_o;
  logic            result_valid_o;
  logic [XLEN-1:0] result_o;
  res_kind_t       kind_o;
  logic            overflow_o;
  logic [XLEN-1:0] hi_o;
  logic [XLEN-1:0] lo_o;

  expect_t         exp_q[$];
  expect_t         head;
  logic [XLEN-1:0] model_hi;
  logic [XLEN-1:0] model_lo;
  logic [31:0]     lfsr_state;
  logic            full_seen;
  int              errors;
  int              cycles;

  mips_exec_top i_dut (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .rs_i           (rs_i),
    .rt_i           (rt_i),
    .full_o         (full_o),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .kind_o         (kind_o),
    .overflow_o     (overflow_o),
    .hi_o           (hi_o),
    .lo_o           (lo_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, %0d results never arrived", cycles, exp_q.size());
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic compare_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // Outputs are registered on the rising edge, so they are sampled on the falling one
  always @(negedge clk) begin
    if (full_o) begin
      full_seen = 1'b1;
    end
    if (arst_n_i && result_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("A result pulse came out with no instruction outstanding");
        errors++;
      end else begin
        head = exp_q.pop_front();
        compare_word("kind_o", 32'(kind_o), 32'(head.kind));
        // HI/LO results carry their value on hi_o and lo_o
        if (head.kind != RES_HILO) begin
          compare_word("result_o", result_o, head.res);
        end
        compare_word("overflow_o", 32'(overflow_o), 32'(head.ovf));
        compare_word("hi_o", hi_o, head.hi);
        compare_word("lo_o", lo_o, head.lo);
      end
    end
  end

  // Remainder in the upper word, quotient in the lower
  function automatic logic [63:0] div_ref(input logic [31:0] a, input logic [31:0] b,
                                          input logic sgn);
    logic        na;
    logic        nb;
    logic [31:0] ma;
    logic [31:0] mb;
    logic [31:0] q;
    logic [31:0] r;
    na = sgn && a[31];
    nb = sgn && b[31];
    ma = na ? -a : a;
    mb = nb ? -b : b;
    if (mb == 0) begin
      q = '1;
      r = ma;
    end else begin
      q = ma / mb;
      r = ma % mb;
    end
    if (na ^ nb) q = -q;
    if (na) r = -r;
    return {r, q};
  endfunction

  // One strobe, held back while full_o is high
  task automatic strobe(input logic [31:0] instr, input logic [31:0] rs, input logic [31:0] rt);
    @(negedge clk);
    while (full_o) @(negedge clk);
    @(posedge clk);
    instr_valid_i <= 1'b1;
    instr_i       <= instr;
    rs_i          <= rs;
    rt_i          <= rt;
    @(posedge clk);
    instr_valid_i <= 1'b0;
  endtask

  task automatic issue_r(input func_t f, input logic [31:0] rs, input logic [31:0] rt,
                         input logic [4:0] sh);
    expect_t     e;
    logic [32:0] wide;
    logic [63:0] prod;
    e.kind = RES_RD;
    e.ovf  = 1'b0;
    e.res  = '0;
    case (f)
      FUNC_SLL:  e.res = rt << sh;
      FUNC_SRL:  e.res = rt >> sh;
      FUNC_SRA:  e.res = $signed(rt) >>> sh;
      FUNC_SLLV: e.res = rt << rs[4:0];
      FUNC_SRLV: e.res = rt >> rs[4:0];
      FUNC_SRAV: e.res = $signed(rt) >>> rs[4:0];
      FUNC_ADD: begin
        wide  = {rs[31], rs} + {rt[31], rt};
        e.res = wide[31:0];
        e.ovf = wide[32] ^ wide[31];
      end
      FUNC_SUB: begin
        wide  = {rs[31], rs} - {rt[31], rt};
        e.res = wide[31:0];
        e.ovf = wide[32] ^ wide[31];
      end
      FUNC_ADDU: e.res = rs + rt;
      FUNC_SUBU: e.res = rs - rt;
      FUNC_AND:  e.res = rs & rt;
      FUNC_OR:   e.res = rs | rt;
      FUNC_XOR:  e.res = rs ^ rt;
      FUNC_NOR:  e.res = ~(rs | rt);
      FUNC_MULT, FUNC_MULTU: begin
        if (f == FUNC_MULT) prod = longint'($signed(rs)) * longint'($signed(rt));
        else prod = {32'h0, rs} * {32'h0, rt};
        {model_hi, model_lo} = prod;
        e.kind = RES_HILO;
      end
      FUNC_DIV: begin
        {model_hi, model_lo} = div_ref(rs, rt, 1'b1);
        e.kind = RES_HILO;
      end
      FUNC_DIVU: begin
        {model_hi, model_lo} = div_ref(rs, rt, 1'b0);
        e.kind = RES_HILO;
      end
      default:   e.res = '0;
    endcase
    e.hi = model_hi;
    e.lo = model_lo;
    exp_q.push_back(e);
    strobe({6'h00, 5'd1, 5'd2, 5'd3, sh, 6'(f)}, rs, rt);
  endtask

  task automatic issue_i(input opcode_t op, input logic [31:0] rs, input logic [15:0] imm);
    expect_t     e;
    logic [31:0] se;
    logic [32:0] wide;
    se     = {{16{imm[15]}}, imm};
    e.kind = RES_RT;
    e.ovf  = 1'b0;
    e.hi   = model_hi;
    e.lo   = model_lo;
    case (op)
      OP_ADDI: begin
        wide  = {rs[31], rs} + {se[31], se};
        e.res = wide[31:0];
        e.ovf = wide[32] ^ wide[31];
      end
      OP_ADDIU: e.res = rs + se;
      OP_SLTI:  e.res = ($signed(rs) < $signed(se)) ? 32'd1 : 32'd0;
      OP_SLTIU: e.res = (rs < se) ? 32'd1 : 32'd0;
      OP_ANDI:  e.res = rs & {16'h0, imm};
      OP_ORI:   e.res = rs | {16'h0, imm};
      OP_XORI:  e.res = rs ^ {16'h0, imm};
      OP_LUI:   e.res = {imm, 16'h0};
      default: begin
        e.res  = rs + se;
        e.kind = RES_ADDR;
      end
    endcase
    exp_q.push_back(e);
    strobe({6'(op), 5'd1, 5'd2, imm}, rs, 32'h0);
  endtask

  `include "tb_tasks.svh"

  initial begin
    arst_n_i      = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    rs_i          = '0;
    rt_i          = '0;
    model_hi      = '0;
    model_lo      = '0;
    lfsr_state    = 32'h216b_73f9;
    full_seen     = 1'b0;
    errors        = 0;
    cycles        = 0;
    repeat (8) @(posedge clk);
    arst_n_i <= 1'b1;
    @(posedge clk);
    test_reg_alu();
    test_imm_ops();
    test_overflow();
    test_mult();
    test_div();
    test_backpressure();
    while (exp_q.size() != 0) @(negedge clk);
    // Idle a while to catch stray pulses
    repeat (10) @(negedge clk);
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== logic/mips_exec_top.sv ====
`timescale 1ns/10ps

module mips_exec_top
  import mips_pkg::*;
(
  input  logic            clk,
  input  logic            arst_n_i,
  input  logic            instr_valid_i,
  input  logic [XLEN-1:0] instr_i,
  input  logic [XLEN-1:0] rs_i,
  input  logic [XLEN-1:0] rt_i,
  output logic            full_o,
  output logic            result_valid_o,
  output logic [XLEN-1:0] result_o,
  output res_kind_t       kind_o,
  output logic            overflow_o,
  output logic [XLEN-1:0] hi_o,
  output logic [XLEN-1:0] lo_o
);

  // Decoder to queue, and queue to execute unit
  op_if wr_bus ();
  op_if rd_bus ();

  assign full_o = wr_bus.full;

  instr_decode i_instr_decode (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .rs_i          (rs_i),
    .rt_i          (rt_i),
    .wr_bus        (wr_bus.producer)
  );

  op_queue i_op_queue (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .wr_bus   (wr_bus.queue),
    .rd_bus   (rd_bus.queue)
  );

  execute_unit i_execute_unit (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .rd_bus         (rd_bus.consumer),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .kind_o         (kind_o),
    .overflow_o     (overflow_o),
    .hi_o           (hi_o),
    .lo_o           (lo_o)
  );

endmodule

// ==== logic/execute_unit.sv ====
`timescale 1ns/10ps

module execute_unit
  import mips_pkg::*;
(
  input  logic            clk,
  input  logic            arst_n_i,
  op_if.consumer          rd_bus,
  output logic            result_valid_o,
  output logic [XLEN-1:0] result_o,
  output res_kind_t       kind_o,
  output logic            overflow_o,
  output logic [XLEN-1:0] hi_o,
  output logic [XLEN-1:0] lo_o
);

  logic              busy;
  logic              pop;
  logic              is_div;
  logic              is_mul;
  logic              start_div;
  logic              div_done;
  logic [XLEN-1:0]   quotient;
  logic [XLEN-1:0]   remainder;
  logic [XLEN-1:0]   a;
  logic [XLEN-1:0]   b;
  logic [XLEN-1:0]   sum;
  logic [XLEN-1:0]   diff;
  logic [2*XLEN-1:0] mul_a;
  logic [2*XLEN-1:0] mul_b;
  logic [2*XLEN-1:0] product;
  logic [XLEN-1:0]   alu_res;
  logic              alu_ovf;
  logic [2*XLEN-1:0] hilo;

  assign a         = rd_bus.rd_opnd_a;
  assign b         = rd_bus.rd_opnd_b;
  assign pop       = !rd_bus.empty && !busy;
  assign rd_bus.pop = pop;
  assign is_div    = rd_bus.rd_alu_op inside {ALU_DIV, ALU_DIVU};
  assign is_mul    = rd_bus.rd_alu_op inside {ALU_MULT, ALU_MULTU};
  assign start_div = pop && is_div;

  assign sum  = a + b;
  assign diff = a - b;

  // One 64-bit multiplier, operands extended by signedness
  assign mul_a   = (rd_bus.rd_alu_op == ALU_MULT) ? {{XLEN{a[XLEN-1]}}, a} : {{XLEN{1'b0}}, a};
  assign mul_b   = (rd_bus.rd_alu_op == ALU_MULT) ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
  assign product = mul_a * mul_b;

  always_comb begin
    alu_res = sum;
    alu_ovf = 1'b0;
    case (rd_bus.rd_alu_op)
      ALU_SLL:  alu_res = a << rd_bus.rd_shamt;
      ALU_SRL:  alu_res = a >> rd_bus.rd_shamt;
      ALU_SRA:  alu_res = $signed(a) >>> rd_bus.rd_shamt;
      ALU_ADD: begin
        // Same operand signs but a different result sign
        alu_res = sum;
        alu_ovf = (a[XLEN-1] == b[XLEN-1]) && (sum[XLEN-1] != a[XLEN-1]);
      end
      ALU_ADDU: alu_res = sum;
      ALU_SUB: begin
        alu_res = diff;
        alu_ovf = (a[XLEN-1] != b[XLEN-1]) && (diff[XLEN-1] != a[XLEN-1]);
      end
      ALU_SUBU: alu_res = diff;
      ALU_AND:  alu_res = a & b;
      ALU_OR:   alu_res = a | b;
      ALU_XOR:  alu_res = a ^ b;
      ALU_NOR:  alu_res = ~(a | b);
      ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, a < b};
      ALU_LUI:  alu_res = {a[XLEN/2-1:0], {(XLEN/2){1'b0}}};
      ALU_MULT, ALU_MULTU: alu_res = product[XLEN-1:0];
      default:  alu_res = sum;
    endcase
  end

  divider i_divider (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .start_i     (start_div),
    .signed_i    (rd_bus.rd_alu_op == ALU_DIV),
    .dividend_i  (a),
    .divisor_i   (b),
    .done_o      (div_done),
    .quotient_o  (quotient),
    .remainder_o (remainder)
  );

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy           <= 1'b0;
      result_valid_o <= 1'b0;
      overflow_o     <= 1'b0;
      hilo           <= '0;
    end else begin
      result_valid_o <= 1'b0;
      overflow_o     <= 1'b0;
      if (div_done) begin
        // HI gets the remainder, LO the quotient
        busy           <= 1'b0;
        result_valid_o <= 1'b1;
        hilo           <= {remainder, quotient};
      end else if (start_div) begin
        busy <= 1'b1;
      end else if (pop) begin
        result_valid_o <= 1'b1;
        overflow_o     <= alu_ovf;
        if (is_mul) begin
          hilo <= product;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (div_done) begin
      result_o <= quotient;
      kind_o   <= RES_HILO;
    end else if (pop && !is_div) begin
      result_o <= alu_res;
      kind_o   <= rd_bus.rd_kind;
    end
  end

  assign hi_o = hilo[2*XLEN-1:XLEN];
  assign lo_o = hilo[XLEN-1:0];

endmodule

// ==== logic/op_queue.sv ====
`timescale 1ns/10ps

module op_queue
  import mips_pkg::*;
(
  input  logic clk,
  input  logic arst_n_i,
  op_if.queue  wr_bus,
  op_if.queue  rd_bus
);

  alu_op_t         mem_alu_op [QUEUE_DEPTH];
  logic [XLEN-1:0] mem_opnd_a [QUEUE_DEPTH];
  logic [XLEN-1:0] mem_opnd_b [QUEUE_DEPTH];
  logic [4:0]      mem_shamt  [QUEUE_DEPTH];
  res_kind_t       mem_kind   [QUEUE_DEPTH];

  logic [QUEUE_PTR_W-1:0] wr_ptr;
  logic [QUEUE_PTR_W-1:0] rd_ptr;
  logic [QUEUE_PTR_W:0]   count;
  logic                   do_push;
  logic                   do_pop;
  logic                   full;
  logic                   empty;

  assign do_push = wr_bus.push && (count != QUEUE_DEPTH);
  assign do_pop  = rd_bus.pop && !empty;
  assign empty   = (count == 0);
  // The decoder push register lags full by one cycle, so one slot stays reserved
  assign full    = (count == QUEUE_DEPTH) || ((count == QUEUE_DEPTH - 1) && wr_bus.push);

  assign wr_bus.full  = full;
  assign rd_bus.empty = empty;

  // Head entry
  assign rd_bus.rd_alu_op = mem_alu_op[rd_ptr];
  assign rd_bus.rd_opnd_a = mem_opnd_a[rd_ptr];
  assign rd_bus.rd_opnd_b = mem_opnd_b[rd_ptr];
  assign rd_bus.rd_shamt  = mem_shamt[rd_ptr];
  assign rd_bus.rd_kind   = mem_kind[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_alu_op[wr_ptr] <= wr_bus.wr_alu_op;
      mem_opnd_a[wr_ptr] <= wr_bus.wr_opnd_a;
      mem_opnd_b[wr_ptr] <= wr_bus.wr_opnd_b;
      mem_shamt[wr_ptr]  <= wr_bus.wr_shamt;
      mem_kind[wr_ptr]   <= wr_bus.wr_kind;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == QUEUE_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == QUEUE_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== logic/instr_decode.sv ====
`timescale 1ns/10ps

module instr_decode
  import mips_pkg::*;
(
  input  logic            clk,
  input  logic            arst_n_i,
  input  logic            instr_valid_i,
  input  logic [XLEN-1:0] instr_i,
  input  logic [XLEN-1:0] rs_i,
  input  logic [XLEN-1:0] rt_i,
  op_if.producer          wr_bus
);

  opcode_t         opcode;
  func_t           funct;
  logic [XLEN-1:0] sign_imm;
  logic [XLEN-1:0] zero_imm;

  logic            op_ok;
  alu_op_t         alu_op;
  logic [XLEN-1:0] opnd_a;
  logic [XLEN-1:0] opnd_b;
  logic [4:0]      shamt;
  res_kind_t       kind;

  assign opcode   = opcode_t'(instr_i[31:26]);
  assign funct    = func_t'(instr_i[5:0]);
  assign sign_imm = {{(XLEN-16){instr_i[15]}}, instr_i[15:0]};
  assign zero_imm = {{(XLEN-16){1'b0}}, instr_i[15:0]};

  always_comb begin
    op_ok  = 1'b1;
    alu_op = ALU_ADDU;
    opnd_a = rs_i;
    opnd_b = rt_i;
    shamt  = instr_i[10:6];
    kind   = RES_RD;
    case (opcode)
      OP_SPECIAL: begin
        case (funct)
          FUNC_SLL:   begin alu_op = ALU_SLL; opnd_a = rt_i; end
          FUNC_SRL:   begin alu_op = ALU_SRL; opnd_a = rt_i; end
          FUNC_SRA:   begin alu_op = ALU_SRA; opnd_a = rt_i; end
          // Variable shifts take the amount from rs
          FUNC_SLLV:  begin alu_op = ALU_SLL; opnd_a = rt_i; shamt = rs_i[4:0]; end
          FUNC_SRLV:  begin alu_op = ALU_SRL; opnd_a = rt_i; shamt = rs_i[4:0]; end
          FUNC_SRAV:  begin alu_op = ALU_SRA; opnd_a = rt_i; shamt = rs_i[4:0]; end
          FUNC_MULT:  begin alu_op = ALU_MULT;  kind = RES_HILO; end
          FUNC_MULTU: begin alu_op = ALU_MULTU; kind = RES_HILO; end
          FUNC_DIV:   begin alu_op = ALU_DIV;   kind = RES_HILO; end
          FUNC_DIVU:  begin alu_op = ALU_DIVU;  kind = RES_HILO; end
          FUNC_ADD:   alu_op = ALU_ADD;
          FUNC_ADDU:  alu_op = ALU_ADDU;
          FUNC_SUB:   alu_op = ALU_SUB;
          FUNC_SUBU:  alu_op = ALU_SUBU;
          FUNC_AND:   alu_op = ALU_AND;
          FUNC_OR:    alu_op = ALU_OR;
          FUNC_XOR:   alu_op = ALU_XOR;
          FUNC_NOR:   alu_op = ALU_NOR;
          default:    op_ok  = 1'b0;
        endcase
      end
      OP_ADDI:  begin alu_op = ALU_ADD;  opnd_b = sign_imm; kind = RES_RT; end
      OP_ADDIU: begin alu_op = ALU_ADDU; opnd_b = sign_imm; kind = RES_RT; end
      OP_SLTI:  begin alu_op = ALU_SLT;  opnd_b = sign_imm; kind = RES_RT; end
      // Sign-extended immediate, compared as unsigned
      OP_SLTIU: begin alu_op = ALU_SLTU; opnd_b = sign_imm; kind = RES_RT; end
      OP_ANDI:  begin alu_op = ALU_AND;  opnd_b = zero_imm; kind = RES_RT; end
      OP_ORI:   begin alu_op = ALU_OR;   opnd_b = zero_imm; kind = RES_RT; end
      OP_XORI:  begin alu_op = ALU_XOR;  opnd_b = zero_imm; kind = RES_RT; end
      OP_LUI:   begin alu_op = ALU_LUI;  opnd_a = zero_imm; kind = RES_RT; end
      OP_LW, OP_SW: begin
        alu_op = ALU_ADDU;
        opnd_b = sign_imm;
        kind   = RES_ADDR;
      end
      default:  op_ok = 1'b0;
    endcase
  end

  // Dropped when the queue reports full or the instruction is unsupported
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_bus.push <= 1'b0;
    end else begin
      wr_bus.push <= instr_valid_i && op_ok && !wr_bus.full;
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid_i) begin
      wr_bus.wr_alu_op <= alu_op;
      wr_bus.wr_opnd_a <= opnd_a;
      wr_bus.wr_opnd_b <= opnd_b;
      wr_bus.wr_shamt  <= shamt;
      wr_bus.wr_kind   <= kind;
    end
  end

endmodule

// ==== logic/divider.sv ====
`timescale 1ns/10ps

module divider
  import mips_pkg::*;
(
  input  logic            clk,
  input  logic            arst_n_i,
  input  logic            start_i,
  input  logic            signed_i,
  input  logic [XLEN-1:0] dividend_i,
  input  logic [XLEN-1:0] divisor_i,
  output logic            done_o,
  output logic [XLEN-1:0] quotient_o,
  output logic [XLEN-1:0] remainder_o
);

  logic                 running;
  logic [DIV_CNT_W-1:0] step_cnt;
  logic [XLEN-1:0]      rem;
  logic [XLEN-1:0]      quo;
  logic [XLEN-1:0]      dvs;
  logic                 neg_q;
  logic                 neg_r;
  logic                 dvd_neg;
  logic                 dvs_neg;
  logic [XLEN:0]        rem_shift;
  logic [XLEN:0]        trial;

  assign dvd_neg = signed_i && dividend_i[XLEN-1];
  assign dvs_neg = signed_i && divisor_i[XLEN-1];

  // Bring down the next dividend bit and try to subtract
  assign rem_shift = {rem, quo[XLEN-1]};
  assign trial     = rem_shift - {1'b0, dvs};

  always_ff @(posedge clk) begin
    if (start_i) begin
      rem   <= '0;
      quo   <= dvd_neg ? -dividend_i : dividend_i;
      dvs   <= dvs_neg ? -divisor_i : divisor_i;
      neg_q <= dvd_neg ^ dvs_neg;
      neg_r <= dvd_neg;
    end else if (running) begin
      if (!trial[XLEN]) begin
        rem <= trial[XLEN-1:0];
        quo <= {quo[XLEN-2:0], 1'b1};
      end else begin
        rem <= rem_shift[XLEN-1:0];
        quo <= {quo[XLEN-2:0], 1'b0};
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      running  <= 1'b0;
      step_cnt <= '0;
      done_o   <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        running  <= 1'b1;
        step_cnt <= '0;
      end else if (running) begin
        step_cnt <= step_cnt + 1'b1;
        if (step_cnt == DIV_CNT_W'(DIV_STEPS - 1)) begin
          running <= 1'b0;
          done_o  <= 1'b1;
        end
      end
    end
  end

  // A zero divisor leaves all ones and the dividend magnitude before the fix-up
  assign quotient_o  = neg_q ? -quo : quo;
  assign remainder_o = neg_r ? -rem : rem;

endmodule

// ==== logic/op_if.sv ====
`timescale 1ns/10ps

interface op_if
  import mips_pkg::*;
();

  logic            push;
  logic            full;
  logic            pop;
  logic            empty;

  // Operation as written by the producer
  alu_op_t         wr_alu_op;
  logic [XLEN-1:0] wr_opnd_a;
  logic [XLEN-1:0] wr_opnd_b;
  logic [4:0]      wr_shamt;
  res_kind_t       wr_kind;

  // Operation at the queue head
  alu_op_t         rd_alu_op;
  logic [XLEN-1:0] rd_opnd_a;
  logic [XLEN-1:0] rd_opnd_b;
  logic [4:0]      rd_shamt;
  res_kind_t       rd_kind;

  modport producer (
    output push, wr_alu_op, wr_opnd_a, wr_opnd_b, wr_shamt, wr_kind,
    input  full
  );

  modport queue (
    input  push, wr_alu_op, wr_opnd_a, wr_opnd_b, wr_shamt, wr_kind, pop,
    output full, empty, rd_alu_op, rd_opnd_a, rd_opnd_b, rd_shamt, rd_kind
  );

  modport consumer (
    output pop,
    input  empty, rd_alu_op, rd_opnd_a, rd_opnd_b, rd_shamt, rd_kind
  );

endinterface

// ==== logic/mips_pkg.sv ====
package mips_pkg;

  // Data path width
  localparam int XLEN = 32;

  // Operation queue between decoder and execute unit
  localparam int QUEUE_DEPTH = 4;
  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

  // One quotient bit per divider step
  localparam int DIV_STEPS = 32;
  localparam int DIV_CNT_W = $clog2(DIV_STEPS);

  // Primary opcode field, instruction bits 31:26
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_ADDI    = 6'h08,
    OP_ADDIU   = 6'h09,
    OP_SLTI    = 6'h0a,
    OP_SLTIU   = 6'h0b,
    OP_ANDI    = 6'h0c,
    OP_ORI     = 6'h0d,
    OP_XORI    = 6'h0e,
    OP_LUI     = 6'h0f,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2b
  } opcode_t;

  // Function field of SPECIAL, instruction bits 5:0
  typedef enum logic [5:0] {
    FUNC_SLL   = 6'h00,
    FUNC_SRL   = 6'h02,
    FUNC_SRA   = 6'h03,
    FUNC_SLLV  = 6'h04,
    FUNC_SRLV  = 6'h06,
    FUNC_SRAV  = 6'h07,
    FUNC_MULT  = 6'h18,
    FUNC_MULTU = 6'h19,
    FUNC_DIV   = 6'h1a,
    FUNC_DIVU  = 6'h1b,
    FUNC_ADD   = 6'h20,
    FUNC_ADDU  = 6'h21,
    FUNC_SUB   = 6'h22,
    FUNC_SUBU  = 6'h23,
    FUNC_AND   = 6'h24,
    FUNC_OR    = 6'h25,
    FUNC_XOR   = 6'h26,
    FUNC_NOR   = 6'h27
  } func_t;

  // Operation carried from decoder to execute unit
  typedef enum logic [4:0] {
    ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
    ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
    ALU_SLT, ALU_SLTU, ALU_LUI,
    ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU
  } alu_op_t;

  // Destination of a result
  typedef enum logic [1:0] {
    RES_RD   = 2'd0,
    RES_RT   = 2'd1,
    RES_ADDR = 2'd2,
    RES_HILO = 2'd3
  } res_kind_t;

endpackage
